//--- fb_pkg.sv
package fb_pkg;

	////////////////////////////////////////////////////////////
	// pixel and video bundle
	////////////////////////////////////////////////////////////

	// rgb888, red in the top byte
	typedef logic [23:0] pix_t;

	// same bundle on the capture side and the display side
	typedef struct packed {
		logic vs;
		logic hs;
		logic de;
		pix_t pix;
	} video_t;

	// active frame size in pixels and lines
	typedef struct packed {
		logic [11:0] hsize;
		logic [11:0] vsize;
	} geom_t;

	////////////////////////////////////////////////////////////
	// memory command channel
	////////////////////////////////////////////////////////////

	typedef enum logic {
		MEM_WRITE = 1'b0,
		MEM_READ  = 1'b1
	} mem_op_e;

	// one burst request, len is beats minus one
	typedef struct packed {
		mem_op_e     op;
		logic [31:0] addr;
		logic [7:0]  len;
	} mem_cmd_t;

	// arbiter output register state
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_WRITE,
		ARB_READ
	} arb_state_e;

	// pixels live in 32-bit words
	localparam int BYTES_PER_PIXEL = 4;

endpackage

//--- frame_sync.sv
`timescale 1ns/1ps

module frame_sync #(
	parameter logic [31:0] FRAME_BLOCK = 32'h0800_0000,
	parameter int          DEF_HSIZE   = 640,
	parameter int          DEF_VSIZE   = 480
) (
	input  logic          clk_pixel,
	input  logic          w_pll_lock,
	input  logic          vs_i,
	input  fb_pkg::geom_t geom_i,
	output logic          frame_start_o,
	output logic          bank_o,
	output fb_pkg::geom_t geom_o,
	output logic [31:0]   wr_base_o,
	output logic [31:0]   rd_base_o
);

	// last vsync sample
	logic vs_q;
	// high in the first cycle with vsync low
	logic vs_fall;

	assign vs_fall = vs_q & ~vs_i;

	////////////////////////////////////////////////////////////
	// edge detect, geometry latch, bank toggle
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_pixel or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			// low so a vsync already high at release gives no edge
			vs_q          <= 1'b0;
			frame_start_o <= 1'b0;
			bank_o        <= 1'b0;
			geom_o.hsize  <= 12'(DEF_HSIZE);
			geom_o.vsize  <= 12'(DEF_VSIZE);
		end else begin
			vs_q          <= vs_i;
			// single cycle pulse, lines up with the new bank
			frame_start_o <= vs_fall;
			if (vs_fall) begin
				bank_o <= ~bank_o;
				geom_o <= geom_i;
			end
		end
	end

	// ping-pong bases, writer and reader always on opposite banks
	assign wr_base_o = bank_o ? FRAME_BLOCK : 32'h0;
	assign rd_base_o = bank_o ? 32'h0 : FRAME_BLOCK;

endmodule

//--- frame_writer.sv
`timescale 1ns/1ps

module frame_writer #(
	parameter int BURST_BEATS = 4
) (
	input  logic             clk_pixel,
	input  logic             w_pll_lock,
	input  fb_pkg::video_t   video_i,
	input  logic             frame_start_i,
	input  logic [31:0]      wr_base_i,
	output fb_pkg::mem_cmd_t cmd_o,
	output logic             cmd_valid_o,
	input  logic             cmd_ready_i,
	output fb_pkg::pix_t     wdata_o,
	output logic             wvalid_o,
	output logic             overflow_o
);
	import fb_pkg::*;

	localparam int          BW   = (BURST_BEATS > 1) ? $clog2(BURST_BEATS) : 1;
	localparam logic [31:0] STEP = 32'(BURST_BEATS * BYTES_PER_PIXEL);

	// pixel index inside the current burst
	logic [BW-1:0] beat_cnt;
	// byte address of the burst being filled
	logic [31:0]   wr_addr;
	logic          burst_done;
	logic          cmd_taken;

	assign burst_done = video_i.de && !frame_start_i && (beat_cnt == BW'(BURST_BEATS - 1));
	assign cmd_taken  = cmd_valid_o && cmd_ready_i;

	////////////////////////////////////////////////////////////
	// write data beat, one cycle behind the pixel
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_pixel or negedge w_pll_lock) begin
		if (!w_pll_lock)
			wvalid_o <= 1'b0;
		else
			wvalid_o <= video_i.de;
	end

	always_ff @(posedge clk_pixel) begin
		if (video_i.de)
			wdata_o <= video_i.pix;
	end

	////////////////////////////////////////////////////////////
	// burst counting and the single pending command
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_pixel or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			beat_cnt    <= '0;
			wr_addr     <= 32'h0;
			cmd_valid_o <= 1'b0;
			overflow_o  <= 1'b0;
		end else begin
			if (frame_start_i) begin
				// new frame, restart at the bank base
				beat_cnt <= '0;
				wr_addr  <= wr_base_i;
			end else if (burst_done) begin
				beat_cnt <= '0;
				wr_addr  <= wr_addr + STEP;
			end else if (video_i.de) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
			if (burst_done)
				cmd_valid_o <= 1'b1;
			else if (cmd_taken)
				cmd_valid_o <= 1'b0;
			// second burst due with the first still waiting, sticky
			if (burst_done && cmd_valid_o && !cmd_taken)
				overflow_o <= 1'b1;
		end
	end

	// held command stays untouched until it transfers
	always_ff @(posedge clk_pixel) begin
		if (burst_done && (!cmd_valid_o || cmd_taken)) begin
			cmd_o.op   <= MEM_WRITE;
			cmd_o.addr <= wr_addr;
			cmd_o.len  <= 8'(BURST_BEATS - 1);
		end
	end

endmodule

//--- frame_reader.sv
`timescale 1ns/1ps

module frame_reader #(
	parameter int BURST_BEATS = 4,
	parameter int FIFO_DEPTH  = 16
) (
	input  logic             clk_pixel,
	input  logic             w_pll_lock,
	input  logic             frame_start_i,
	input  logic [31:0]      rd_base_i,
	input  fb_pkg::geom_t    geom_i,
	output fb_pkg::mem_cmd_t cmd_o,
	output logic             cmd_valid_o,
	input  logic             cmd_ready_i,
	input  fb_pkg::pix_t     rdata_i,
	input  logic             rvalid_i,
	input  logic             pix_req_i,
	output fb_pkg::pix_t     pix_o
);
	import fb_pkg::*;

	localparam int          PW   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	// one spare bit, stale beats from an old frame may pile up
	localparam int          CW   = $clog2(FIFO_DEPTH + 1) + 1;
	localparam logic [31:0] STEP = 32'(BURST_BEATS * BYTES_PER_PIXEL);

	pix_t          fifo_mem [FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] fifo_cnt;
	// beats requested for this frame and not yet back
	logic [CW-1:0] outstanding;
	// beats of an earlier frame still to come, thrown away
	logic [CW-1:0] drop_cnt;
	logic [31:0]   rd_addr;
	logic [31:0]   end_addr;
	logic          arrive_new;
	logic          arrive_old;
	logic          push;
	logic          pop;
	logic          issue;

	assign arrive_new = rvalid_i && (drop_cnt == '0);
	assign arrive_old = rvalid_i && (drop_cnt != '0);
	assign push       = arrive_new && !frame_start_i;
	// empty pops are ignored, display then repeats the last word
	assign pop        = pix_req_i && (fifo_cnt != '0) && !frame_start_i;
	// room for a whole burst, counting what is already in flight
	assign issue      = !cmd_valid_o && !frame_start_i && (rd_addr < end_addr) &&
		(int'(fifo_cnt) + int'(outstanding) + BURST_BEATS <= FIFO_DEPTH);
	assign pix_o      = fifo_mem[rd_ptr];

	////////////////////////////////////////////////////////////
	// read command generation
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_pixel or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			rd_addr     <= 32'h0;
			end_addr    <= 32'h0;
			cmd_valid_o <= 1'b0;
			outstanding <= '0;
			drop_cnt    <= '0;
		end else begin
			if (issue)
				cmd_valid_o <= 1'b1;
			else if (cmd_ready_i)
				cmd_valid_o <= 1'b0;
			if (frame_start_i) begin
				rd_addr     <= rd_base_i;
				end_addr    <= rd_base_i +
					32'(geom_i.hsize) * 32'(geom_i.vsize) * BYTES_PER_PIXEL;
				// everything still owed, a held command included, is stale now
				drop_cnt    <= drop_cnt + outstanding - CW'(rvalid_i);
				outstanding <= '0;
			end else begin
				if (issue)
					rd_addr <= rd_addr + STEP;
				drop_cnt    <= drop_cnt - CW'(arrive_old);
				outstanding <= outstanding + (issue ? CW'(BURST_BEATS) : '0) -
					CW'(arrive_new);
			end
		end
	end

	always_ff @(posedge clk_pixel) begin
		if (issue) begin
			cmd_o.op   <= MEM_READ;
			cmd_o.addr <= rd_addr;
			cmd_o.len  <= 8'(BURST_BEATS - 1);
		end
	end

	////////////////////////////////////////////////////////////
	// read data fifo, flushed at frame start
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_pixel or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
		end else if (frame_start_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			fifo_cnt <= fifo_cnt + CW'(push) - CW'(pop);
		end
	end

	always_ff @(posedge clk_pixel) begin
		if (push)
			fifo_mem[wr_ptr] <= rdata_i;
	end

endmodule

//--- cmd_arbiter.sv
`timescale 1ns/1ps

module cmd_arbiter (
	input  logic             clk_pixel,
	input  logic             w_pll_lock,
	input  fb_pkg::mem_cmd_t wr_cmd_i,
	input  logic             wr_valid_i,
	output logic             wr_ready_o,
	input  fb_pkg::mem_cmd_t rd_cmd_i,
	input  logic             rd_valid_i,
	output logic             rd_ready_o,
	output fb_pkg::mem_cmd_t cmd_o,
	output logic             cmd_valid_o,
	input  logic             cmd_ready_i
);
	import fb_pkg::*;

	arb_state_e state;
	// round robin, set means read goes first on a tie
	logic       prio_rd;
	// output register empty or draining this cycle
	logic       free;
	logic       grant_wr;
	logic       grant_rd;

	assign free     = (state == ARB_IDLE) || cmd_ready_i;
	assign grant_wr = free && wr_valid_i && (!rd_valid_i || !prio_rd);
	assign grant_rd = free && rd_valid_i && (!wr_valid_i || prio_rd);

	// requester transfers on the edge where it is granted
	assign wr_ready_o  = grant_wr;
	assign rd_ready_o  = grant_rd;
	assign cmd_valid_o = (state != ARB_IDLE);

	////////////////////////////////////////////////////////////
	// output register state and priority
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_pixel or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			state   <= ARB_IDLE;
			// write wins the first tie
			prio_rd <= 1'b0;
		end else if (grant_wr) begin
			state   <= ARB_WRITE;
			prio_rd <= 1'b1;
		end else if (grant_rd) begin
			state   <= ARB_READ;
			prio_rd <= 1'b0;
		end else if (free) begin
			state   <= ARB_IDLE;
		end
	end

	// loaded only when free, so a stalled command holds
	always_ff @(posedge clk_pixel) begin
		if (grant_wr)
			cmd_o <= wr_cmd_i;
		else if (grant_rd)
			cmd_o <= rd_cmd_i;
	end

endmodule

//--- lcd_timing.sv
`timescale 1ns/1ps

module lcd_timing #(
	parameter int H_BLANK = 6,
	parameter int V_BLANK = 2
) (
	input  logic           clk_pixel,
	input  logic           w_pll_lock,
	input  logic           frame_start_i,
	input  fb_pkg::geom_t  geom_i,
	input  fb_pkg::pix_t   pix_i,
	output logic           pix_req_o,
	output fb_pkg::video_t video_o
);
	import fb_pkg::*;

	// idle until the first frame start
	logic        run;
	// one bit wider than geometry so size plus blank fits
	logic [12:0] h_cnt;
	logic [12:0] v_cnt;
	logic [12:0] h_last;
	logic [12:0] v_last;
	logic        h_act;
	logic        v_act;
	logic        de_q;
	logic        hs_q;
	logic        vs_q;
	pix_t        pix_q;

	assign h_last = 13'(geom_i.hsize) + 13'(H_BLANK) - 13'd1;
	assign v_last = 13'(geom_i.vsize) + 13'(V_BLANK) - 13'd1;
	assign h_act  = h_cnt < 13'(geom_i.hsize);
	assign v_act  = v_cnt < 13'(geom_i.vsize);

	// one cycle ahead of de
	assign pix_req_o = run && !frame_start_i && h_act && v_act;

	////////////////////////////////////////////////////////////
	// horizontal and vertical counters
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_pixel or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			run   <= 1'b0;
			h_cnt <= 13'd0;
			v_cnt <= 13'd0;
		end else if (frame_start_i) begin
			run   <= 1'b1;
			h_cnt <= 13'd0;
			// enter at the first blank line, gives the reader time to prefetch
			v_cnt <= 13'(geom_i.vsize);
		end else if (run) begin
			if (h_cnt >= h_last) begin
				h_cnt <= 13'd0;
				v_cnt <= (v_cnt >= v_last) ? 13'd0 : v_cnt + 13'd1;
			end else begin
				h_cnt <= h_cnt + 13'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// output bundle, syncs high in blanking
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_pixel or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			de_q <= 1'b0;
			hs_q <= 1'b0;
			vs_q <= 1'b0;
		end else begin
			de_q <= pix_req_o;
			hs_q <= run && !h_act;
			vs_q <= run && !v_act;
		end
	end

	// fifo head captured on the request
	always_ff @(posedge clk_pixel) begin
		if (pix_req_o)
			pix_q <= pix_i;
	end

	assign video_o = '{vs: vs_q, hs: hs_q, de: de_q, pix: pix_q};

endmodule

//--- frame_buffer_top.sv
`timescale 1ns/1ps

module frame_buffer_top #(
	parameter int          BURST_BEATS = 4,
	parameter logic [31:0] FRAME_BLOCK = 32'h0800_0000,
	parameter int          H_BLANK     = 6,
	parameter int          V_BLANK     = 2,
	parameter int          FIFO_DEPTH  = 16,
	parameter int          DEF_HSIZE   = 640,
	parameter int          DEF_VSIZE   = 480
) (
	input  logic             clk_pixel,
	input  logic             w_pll_lock,
	input  fb_pkg::video_t   in_video_i,
	input  fb_pkg::geom_t    geom_i,
	output fb_pkg::mem_cmd_t mem_cmd_o,
	output logic             mem_cmd_valid_o,
	input  logic             mem_cmd_ready_i,
	output fb_pkg::pix_t     mem_wdata_o,
	output logic             mem_wvalid_o,
	input  fb_pkg::pix_t     mem_rdata_i,
	input  logic             mem_rvalid_i,
	output fb_pkg::video_t   lcd_video_o,
	output logic             bank_o
);
	import fb_pkg::*;

	// frame control from the input vsync
	logic        frame_start;
	geom_t       frame_geom;
	logic [31:0] wr_base;
	logic [31:0] rd_base;
	// requester to arbiter
	mem_cmd_t    wr_cmd;
	logic        wr_valid;
	logic        wr_ready;
	mem_cmd_t    rd_cmd;
	logic        rd_valid;
	logic        rd_ready;
	// reader fifo to display
	logic        pix_req;
	pix_t        lcd_pix;

	////////////////////////////////////////////////////////////
	// capture side
	////////////////////////////////////////////////////////////
	frame_sync #(
		.FRAME_BLOCK (FRAME_BLOCK),
		.DEF_HSIZE   (DEF_HSIZE),
		.DEF_VSIZE   (DEF_VSIZE)
	) u_frame_sync (
		.clk_pixel     (clk_pixel),
		.w_pll_lock    (w_pll_lock),
		.vs_i          (in_video_i.vs),
		.geom_i        (geom_i),
		.frame_start_o (frame_start),
		.bank_o        (bank_o),
		.geom_o        (frame_geom),
		.wr_base_o     (wr_base),
		.rd_base_o     (rd_base)
	);

	// overflow is watched by the bound checker only
	frame_writer #(
		.BURST_BEATS (BURST_BEATS)
	) u_frame_writer (
		.clk_pixel     (clk_pixel),
		.w_pll_lock    (w_pll_lock),
		.video_i       (in_video_i),
		.frame_start_i (frame_start),
		.wr_base_i     (wr_base),
		.cmd_o         (wr_cmd),
		.cmd_valid_o   (wr_valid),
		.cmd_ready_i   (wr_ready),
		.wdata_o       (mem_wdata_o),
		.wvalid_o      (mem_wvalid_o),
		.overflow_o    ()
	);

	////////////////////////////////////////////////////////////
	// display side
	////////////////////////////////////////////////////////////
	frame_reader #(
		.BURST_BEATS (BURST_BEATS),
		.FIFO_DEPTH  (FIFO_DEPTH)
	) u_frame_reader (
		.clk_pixel     (clk_pixel),
		.w_pll_lock    (w_pll_lock),
		.frame_start_i (frame_start),
		.rd_base_i     (rd_base),
		.geom_i        (frame_geom),
		.cmd_o         (rd_cmd),
		.cmd_valid_o   (rd_valid),
		.cmd_ready_i   (rd_ready),
		.rdata_i       (mem_rdata_i),
		.rvalid_i      (mem_rvalid_i),
		.pix_req_i     (pix_req),
		.pix_o         (lcd_pix)
	);

	lcd_timing #(
		.H_BLANK (H_BLANK),
		.V_BLANK (V_BLANK)
	) u_lcd_timing (
		.clk_pixel     (clk_pixel),
		.w_pll_lock    (w_pll_lock),
		.frame_start_i (frame_start),
		.geom_i        (frame_geom),
		.pix_i         (lcd_pix),
		.pix_req_o     (pix_req),
		.video_o       (lcd_video_o)
	);

	////////////////////////////////////////////////////////////
	// single memory command channel
	////////////////////////////////////////////////////////////
	cmd_arbiter u_cmd_arbiter (
		.clk_pixel   (clk_pixel),
		.w_pll_lock  (w_pll_lock),
		.wr_cmd_i    (wr_cmd),
		.wr_valid_i  (wr_valid),
		.wr_ready_o  (wr_ready),
		.rd_cmd_i    (rd_cmd),
		.rd_valid_i  (rd_valid),
		.rd_ready_o  (rd_ready),
		.cmd_o       (mem_cmd_o),
		.cmd_valid_o (mem_cmd_valid_o),
		.cmd_ready_i (mem_cmd_ready_i)
	);

endmodule

//--- frame_buffer_chk.sv
`timescale 1ns/1ps

module frame_buffer_chk (
	input  logic             clk_pixel,
	input  logic             w_pll_lock,
	input  fb_pkg::mem_cmd_t cmd_i,
	input  logic             valid_i,
	input  logic             ready_i,
	input  logic             overflow_i
);

	////////////////////////////////////////////////////////////
	// valid/ready rules on a command port
	////////////////////////////////////////////////////////////

	// stalled command keeps every field
	a_cmd_held: assert property (@(posedge clk_pixel) disable iff (!w_pll_lock)
		valid_i && !ready_i |=> $stable(cmd_i))
		else $error("command changed while stalled");

	// no withdrawal before the transfer
	a_valid_held: assert property (@(posedge clk_pixel) disable iff (!w_pll_lock)
		valid_i && !ready_i |=> valid_i)
		else $error("valid dropped before transfer");

	a_no_overflow: assert property (@(posedge clk_pixel) disable iff (!w_pll_lock)
		!overflow_i)
		else $error("second write burst due while one still pending");

endmodule

bind cmd_arbiter frame_buffer_chk u_arb_chk (.clk_pixel(clk_pixel), .w_pll_lock(w_pll_lock),
	.cmd_i(cmd_o), .valid_i(cmd_valid_o), .ready_i(cmd_ready_i), .overflow_i(1'b0));

bind frame_writer frame_buffer_chk u_wr_chk (.clk_pixel(clk_pixel), .w_pll_lock(w_pll_lock),
	.cmd_i(cmd_o), .valid_i(cmd_valid_o), .ready_i(cmd_ready_i), .overflow_i(overflow_o));

//--- tb_frame_buffer.sv
`timescale 1ns/1ps

module tb_frame_buffer;
	import fb_pkg::*;

	localparam int          BURST   = 4;
	localparam logic [31:0] FB      = 32'h0800_0000;
	localparam int          NROWS   = 5;
	localparam int          TIMEOUT = 20000;

	// one frame of stimulus and the bank it must land in
	typedef struct packed {
		logic [11:0] h;
		logic [11:0] v;
		logic        bank;
	} row_t;

	logic        clk_pixel;
	logic        w_pll_lock;
	video_t      in_video;
	geom_t       geom;
	mem_cmd_t    mem_cmd;
	logic        mem_cmd_valid;
	logic        mem_cmd_ready;
	pix_t        mem_wdata;
	logic        mem_wvalid;
	pix_t        mem_rdata;
	logic        mem_rvalid;
	video_t      lcd_video;
	logic        bank;
	integer      seed = 32'ha64d_f9ad;
	integer      pix_seed = 32'ha64d_f9ad;
	row_t        frame_tab [NROWS];
	// reference words from the driven pixels, model words from the DUT writes
	pix_t        ref_mem [logic [31:0]];
	pix_t        model_mem [logic [31:0]];
	pix_t        wbeat_q [$];
	logic [31:0] rbeat_q [$];
	logic [31:0] exp_wr;
	logic [31:0] exp_rd;
	int          total;
	int          cur_h;
	int          cur_v;
	int          wr_k;
	int          rd_k;
	int          disp_k;
	int          disp_run;
	int          disp_lines;
	logic        disp_on;
	logic        prev_hs;
	logic        prev_vs;
	logic        last_rd;
	mem_cmd_t    prev_cmd;
	logic        prev_stall;
	int          errors;

	frame_buffer_top #(
		.BURST_BEATS (BURST),
		.FRAME_BLOCK (FB)
	) DUT (
		.clk_pixel       (clk_pixel),
		.w_pll_lock      (w_pll_lock),
		.in_video_i      (in_video),
		.geom_i          (geom),
		.mem_cmd_o       (mem_cmd),
		.mem_cmd_valid_o (mem_cmd_valid),
		.mem_cmd_ready_i (mem_cmd_ready),
		.mem_wdata_o     (mem_wdata),
		.mem_wvalid_o    (mem_wvalid),
		.mem_rdata_i     (mem_rdata),
		.mem_rvalid_i    (mem_rvalid),
		.lcd_video_o     (lcd_video),
		.bank_o          (bank)
	);

	initial begin
		clk_pixel = 1'b0;
		forever #2 clk_pixel = ~clk_pixel;
	end

	// never written words, every address bit matters
	function automatic pix_t fill_word(logic [31:0] a);
		return a[23:0] ^ {a[7:0], a[31:16]} ^ 24'h5a3c96;
	endfunction

	function automatic pix_t expect_pix(logic [31:0] a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
	endfunction

	function automatic pix_t model_word(logic [31:0] a);
		return model_mem.exists(a) ? model_mem[a] : fill_word(a);
	endfunction

	task automatic stop_with_error();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic value_error(string name, logic [63:0] got, logic [63:0] exp);
		errors++;
		$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		stop_with_error();
	endtask

	task automatic plain_error(string what);
		errors++;
		$display("at %0t: %s", $time, what);
		stop_with_error();
	endtask

	////////////////////////////////////////////////////////////
	// memory model, sampling side
	////////////////////////////////////////////////////////////
	always @(posedge clk_pixel) begin : mem_sample
		pix_t        beat;
		logic [31:0] a;
		if (w_pll_lock) begin
			if (mem_wvalid)
				wbeat_q.push_back(mem_wdata);
			assert (!DUT.u_frame_writer.overflow_o) else plain_error("write command overflow");
			// held command must not move
			if (prev_stall)
				assert (mem_cmd == prev_cmd) else value_error("mem_cmd_o", mem_cmd, prev_cmd);
			// tie goes to the side not served last
			if (DUT.wr_valid && DUT.rd_valid && (DUT.wr_ready || DUT.rd_ready))
				assert (DUT.wr_ready == last_rd) else value_error("wr_ready", DUT.wr_ready, last_rd);
			if (DUT.wr_ready)
				last_rd = 1'b0;
			else if (DUT.rd_ready)
				last_rd = 1'b1;
			prev_stall = mem_cmd_valid && !mem_cmd_ready;
			prev_cmd   = mem_cmd;
			if (mem_cmd_valid && mem_cmd_ready) begin
				assert (mem_cmd.len == 8'(BURST - 1)) else value_error("len", mem_cmd.len, BURST - 1);
				if (mem_cmd.op == MEM_WRITE) begin
					a = exp_wr + 32'(wr_k * BURST * 4);
					assert (mem_cmd.addr == a) else value_error("write addr", mem_cmd.addr, a);
					for (int i = 0; i < BURST; i++) begin
						assert (wbeat_q.size() != 0) else plain_error("write command without data");
						beat = wbeat_q.pop_front();
						a    = mem_cmd.addr + 32'(4 * i);
						assert (beat == expect_pix(a)) else value_error("mem_wdata_o", beat, expect_pix(a));
						model_mem[a] = beat;
					end
					wr_k++;
				end else begin
					a = exp_rd + 32'(rd_k * BURST * 4);
					assert (rd_k < total / BURST) else plain_error("read command past the frame end");
					assert (mem_cmd.addr == a) else value_error("read addr", mem_cmd.addr, a);
					for (int i = 0; i < BURST; i++)
						rbeat_q.push_back(mem_cmd.addr + 32'(4 * i));
					rd_k++;
				end
			end
		end
	end

	// memory model drive side, random stalls on ready and read data
	always @(negedge clk_pixel) begin : mem_drive
		logic [31:0] a;
		if (w_pll_lock) begin
			mem_cmd_ready = (($random(seed) & 7) != 0);
			if (rbeat_q.size() != 0 && ($random(seed) & 15) != 0) begin
				a          = rbeat_q.pop_front();
				mem_rvalid = 1'b1;
				mem_rdata  = model_word(a);
			end else begin
				mem_rvalid = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// display monitor, first pass after each frame start
	////////////////////////////////////////////////////////////
	always @(negedge clk_pixel) begin
		if (w_pll_lock) begin
			if (DUT.frame_start) begin
				disp_on    = 1'b1;
				disp_k     = 0;
				disp_run   = 0;
				disp_lines = 0;
			end else if (disp_on) begin
				if (lcd_video.de) begin
					assert (lcd_video.pix == expect_pix(exp_rd + 32'(4 * disp_k)))
						else value_error("lcd_video_o.pix", lcd_video.pix,
							expect_pix(exp_rd + 32'(4 * disp_k)));
					// syncs low in the active area
					assert (!lcd_video.hs && !lcd_video.vs)
						else value_error("lcd_video_o.hs/vs", {lcd_video.hs, lcd_video.vs}, 0);
					// a line opens out of hblank, the first one also out of vblank
					if (disp_run == 0) begin
						assert (prev_hs) else value_error("lcd_video_o.hs before line", prev_hs, 1);
						assert (prev_vs == (disp_lines == 0))
							else value_error("lcd_video_o.vs before line", prev_vs,
								disp_lines == 0);
					end
					disp_k++;
					disp_run++;
				end else if (disp_run != 0) begin
					assert (disp_run == cur_h) else value_error("de cycles per line", disp_run, cur_h);
					// hblank right after the last active pixel
					assert (lcd_video.hs && !lcd_video.vs)
						else value_error("lcd_video_o.hs/vs", {lcd_video.hs, lcd_video.vs}, 2'b10);
					disp_run = 0;
					disp_lines++;
					if (disp_lines == cur_v)
						disp_on = 1'b0;
				end
			end
			prev_hs = lcd_video.hs;
			prev_vs = lcd_video.vs;
		end
	end

	// one input frame, then wait for writes, reads and display to finish
	task automatic run_frame(row_t r);
		int n;
		int t;
		geom          = '{hsize: r.h, vsize: r.v};
		in_video.vs   = 1'b1;
		repeat (4) @(negedge clk_pixel);
		exp_wr        = r.bank ? FB : 32'h0;
		exp_rd        = r.bank ? 32'h0 : FB;
		total         = int'(r.h) * int'(r.v);
		cur_h         = int'(r.h);
		cur_v         = int'(r.v);
		wr_k          = 0;
		rd_k          = 0;
		disp_lines    = 0;
		in_video.vs   = 1'b0;
		repeat (2) @(negedge clk_pixel);
		assert (bank == r.bank) else value_error("bank_o", bank, r.bank);
		assert (DUT.wr_base == exp_wr) else value_error("wr_base", DUT.wr_base, exp_wr);
		assert (DUT.rd_base == exp_rd) else value_error("rd_base", DUT.rd_base, exp_rd);
		n = 0;
		for (int y = 0; y < cur_v; y++) begin
			for (int x = 0; x < cur_h; x++) begin
				in_video.de  = 1'b1;
				in_video.pix = pix_t'($random(pix_seed));
				ref_mem[exp_wr + 32'(4 * n)] = in_video.pix;
				n++;
				@(negedge clk_pixel);
				// gap so a write burst is due only every eight cycles
				in_video.de = 1'b0;
				@(negedge clk_pixel);
			end
			repeat (4) @(negedge clk_pixel);
		end
		t = 0;
		while (!(wr_k == total / BURST && rd_k == total / BURST &&
				disp_lines == cur_v && !disp_on)) begin
			@(negedge clk_pixel);
			t++;
			if (t > TIMEOUT)
				plain_error("timeout waiting for the frame to drain");
		end
		assert (wbeat_q.size() == 0) else plain_error("write beats left without a command");
	endtask

	initial begin
		errors        = 0;
		last_rd       = 1'b1;
		prev_stall    = 1'b0;
		prev_cmd      = '0;
		disp_on       = 1'b0;
		disp_lines    = 0;
		prev_hs       = 1'b0;
		prev_vs       = 1'b0;
		wr_k          = 0;
		rd_k          = 0;
		total         = 0;
		exp_wr        = 32'h0;
		exp_rd        = FB;
		in_video      = '0;
		geom          = '0;
		mem_cmd_ready = 1'b0;
		mem_rvalid    = 1'b0;
		mem_rdata     = '0;
		w_pll_lock    = 1'b0;
		// sizes and the bank each frame is written to
		frame_tab[0]  = '{h: 12'd8,  v: 12'd2, bank: 1'b1};
		frame_tab[1]  = '{h: 12'd16, v: 12'd2, bank: 1'b0};
		frame_tab[2]  = '{h: 12'd4,  v: 12'd4, bank: 1'b1};
		frame_tab[3]  = '{h: 12'd8,  v: 12'd1, bank: 1'b0};
		frame_tab[4]  = '{h: 12'd8,  v: 12'd2, bank: 1'b1};
		repeat (16) @(negedge clk_pixel);
		w_pll_lock = 1'b1;
		@(negedge clk_pixel);
		assert (!mem_cmd_valid) else value_error("mem_cmd_valid_o", mem_cmd_valid, 0);
		assert (!mem_wvalid) else value_error("mem_wvalid_o", mem_wvalid, 0);
		assert (!lcd_video.de) else value_error("lcd_video_o.de", lcd_video.de, 0);
		assert (!bank) else value_error("bank_o", bank, 0);
		for (int i = 0; i < NROWS; i++)
			run_frame(frame_tab[i]);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- frame_buffer.f
fb_pkg.sv
frame_sync.sv
frame_writer.sv
frame_reader.sv
cmd_arbiter.sv
lcd_timing.sv
frame_buffer_top.sv
frame_buffer_chk.sv
tb_frame_buffer.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_frame_buffer
FILELIST  = frame_buffer.f
PASS      = Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir
